/* Bender.yml */
package:
  name: nora_glue

sources:
  - src/nora_pkg.sv
  - src/blinker.sv
  - src/cpu_bus_sampler.sv
  - src/cpu_pin_ctrl.sv
  - src/via_gpio.sv
  - src/nora_top.sv
  - target: test
    files:
      - bench/nora_props.sv
      - bench/nora_checker.sv
      - bench/nora_tb.sv

/* bench/nora_checker.sv */
// dut output checker
`timescale 1ns/100ps

module nora_checker (
    input  logic             clk6x,
    input  logic             reset_i,
    input  nora_pkg::trace_t act_trace_i,
    input  nora_pkg::trace_t exp_trace_i,
    input  logic [3:0]       act_lines_i,   // resn, irqn, nmin, abortn
    input  logic [3:0]       exp_lines_i,
    input  logic [2:0]       act_drive_i,   // cd, md, mal
    input  logic [2:0]       exp_drive_i,
    input  logic [6:0]       act_pins_i,    // nes clk, latch, scl drv, scl, sda pull, leds
    input  logic [6:0]       exp_pins_i,
    input  logic             rd_valid_i,
    input  logic [7:0]       act_rd_i,
    input  logic [7:0]       exp_rd_i,
    output int               err_cnt_o
);
    import nora_pkg::*;

    initial err_cnt_o = 0;

    // registered status flags of the trace
    function automatic logic [7:0] status_bits(trace_t t);
        return {t.sob_x, t.sob_m, t.sync_vpa, t.mln, t.vpn, t.vda, t.ef, t.rwn};
    endfunction

    // fields that follow their inputs in the same cycle
    function automatic logic [47:0] live_bits(trace_t t);
        return 48'({t.mah_hi, t.cd, t.zero, t.cresn, t.cirqn, t.cnmin, t.cabortn, t.crdy});
    endfunction

    task automatic compare(input string name, input logic [47:0] exp, input logic [47:0] act);
        if (act !== exp)
        begin
            err_cnt_o++;
            $display("ERROR %s expected %0h actual %0h at %0t", name, exp, act, $time);
        end
    endtask

    // sample mid cycle, inputs and registers settled
    always @(negedge clk6x)
    begin
        if (!reset_i)
        begin
            compare("trace_addr", 48'(exp_trace_i.addr), 48'(act_trace_i.addr));
            compare("trace_status", 48'(status_bits(exp_trace_i)),
                    48'(status_bits(act_trace_i)));
            compare("trace_live", live_bits(exp_trace_i), live_bits(act_trace_i));
            compare("irq_lines", 48'(exp_lines_i), 48'(act_lines_i));
            compare("drive_en", 48'(exp_drive_i), 48'(act_drive_i));
            compare("gpio_pins", 48'(exp_pins_i), 48'(act_pins_i));
            if (rd_valid_i)
                compare("read_data", 48'(exp_rd_i), 48'(act_rd_i));  // only while reading
        end
    end

endmodule

/* bench/nora_props.sv */
// reset and strobe capture properties
`timescale 1ns/100ps

module nora_props (
    input logic        clk6x,
    input logic        reset_i,
    input logic [31:0] state_i,     // watched register bits
    input logic [31:0] strobe_i     // strobe allowed to move each bit
);
    int fail_cnt = 0;

    // state clear one cycle into reset
    assert property (@(posedge clk6x) reset_i |=> (state_i == '0))
    else
    begin
        $error("state not cleared by reset");
        fail_cnt++;
    end

    // a bit moves only the cycle after its own strobe
    assert property (@(posedge clk6x) disable iff (reset_i)
        !$past(reset_i) |-> (((state_i ^ $past(state_i)) & ~$past(strobe_i)) == '0))
    else
    begin
        $error("register bit changed without its strobe");
        fail_cnt++;
    end

endmodule

// address and status flags, sob_m on release_wr, rest on latch_ad
bind cpu_bus_sampler nora_props props_smp (
    .clk6x    (clk6x),
    .reset_i  (reset_i),
    .state_i  ({8'd0, cpu_ab_r, status_r}),     // top byte unused
    .strobe_i ({8'd0,
                {17{strobes_i.latch_ad}},
                strobes_i.release_wr,
                {6{strobes_i.latch_ad}}})
);

// port registers move only on a slave write
bind via_gpio nora_props props_via (
    .clk6x    (clk6x),
    .reset_i  (reset_i),
    .state_i  (regs_r),
    .strobe_i ({32{wr_en}})
);

/* bench/nora_tb.sv */
// nora glue testbench
`timescale 1ns/100ps

module nora_tb;
    import nora_pkg::*;

    localparam int RESET_CYC  = 10;
    localparam int BLINK_WAIT = 4 * BLINK_TOP;     // led0 must toggle within this
    localparam int RAND_CYC   = 1920;
    localparam int MAX_CYCLES = 2 * (RESET_CYC + BLINK_WAIT + RAND_CYC);   // twice the test length

    logic             clk6x;
    logic             reset_i;
    phase_strobes_t   strobes;
    logic [CAH_W-1:0] ca;
    logic [MAL_W-1:0] mal;
    cpu_pins_t        cpu_pins;
    logic             cputype02;
    logic [DB_W-1:0]  cd;
    logic [MAH_W-1:0] mah;
    logic             crdy, cphi2, cbe, mrdn;
    irq_ctrl_t        irq_ctrl;
    logic             virqn, nmi_req_n;
    slv_bus_t         slv;
    logic [1:0]       nesdata;
    logic             i2c_scl, i2c_sda;

    // dut outputs
    logic [DB_W-1:0]  slv_datard;
    logic             nesclock, neslatch, scl_drive, scl, sda_pull;
    logic [1:0]       cpuled;
    logic             cresn, cirqn, cnmin, cabortn;
    logic             cd_drive, md_drive, mal_drive;
    trace_t           trace;

    // reference model state
    logic             type02_m;
    logic [CAB_W-1:0] ab_m;
    cpu_status_t      st_m;
    gpio_regs_t       regs_m;
    logic             mrdn_m;
    int               blink_cnt_m;
    logic             blink_m;

    // expected outputs
    logic [3:0]       exp_lines;    // resn, irqn, nmin, abortn
    logic [2:0]       exp_drive;    // cd, md, mal
    logic [6:0]       exp_pins;
    logic [7:0]       exp_rd;
    logic             rd_valid;
    trace_t           exp_trace;

    logic [15:0]      lfsr_r;
    int               check_errs;
    int               other_errs;
    int               prop_errs;
    int               cycle_cnt;

    initial clk6x = 1'b0;
    always #50 clk6x = ~clk6x;      // 100 ns period

    nora_top dut0 (
        .clk6x        (clk6x),
        .reset_i      (reset_i),
        .strobes_i    (strobes),
        .ca_i         (ca),
        .mal_i        (mal),
        .cpu_pins_i   (cpu_pins),
        .cputype02_i  (cputype02),
        .cd_i         (cd),
        .mah_i        (mah),
        .crdy_i       (crdy),
        .cphi2_i      (cphi2),
        .cbe_i        (cbe),
        .mrdn_i       (mrdn),
        .irq_ctrl_i   (irq_ctrl),
        .virqn_i      (virqn),
        .nmi_req_n_i  (nmi_req_n),
        .slv_i        (slv),
        .slv_datard_o (slv_datard),
        .nesdata_i    (nesdata),
        .i2c_scl_i    (i2c_scl),
        .i2c_sda_i    (i2c_sda),
        .nesclock_o   (nesclock),
        .neslatch_o   (neslatch),
        .scl_drive_o  (scl_drive),
        .scl_o        (scl),
        .sda_pull_o   (sda_pull),
        .cpuled_o     (cpuled),
        .cresn_o      (cresn),
        .cirqn_o      (cirqn),
        .cnmin_o      (cnmin),
        .cabortn_o    (cabortn),
        .cd_drive_o   (cd_drive),
        .md_drive_o   (md_drive),
        .mal_drive_o  (mal_drive),
        .trace_o      (trace)
    );

    nora_checker chk0 (
        .clk6x       (clk6x),
        .reset_i     (reset_i),
        .act_trace_i (trace),
        .exp_trace_i (exp_trace),
        .act_lines_i ({cresn, cirqn, cnmin, cabortn}),
        .exp_lines_i (exp_lines),
        .act_drive_i ({cd_drive, md_drive, mal_drive}),
        .exp_drive_i (exp_drive),
        .act_pins_i  ({nesclock, neslatch, scl_drive, scl, sda_pull, cpuled}),
        .exp_pins_i  (exp_pins),
        .rd_valid_i  (rd_valid),
        .act_rd_i    (slv_datard),
        .exp_rd_i    (exp_rd),
        .err_cnt_o   (check_errs)
    );

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb     = lfsr_r[15] ^ lfsr_r[13] ^ lfsr_r[12] ^ lfsr_r[10];
            lfsr_r = {lfsr_r[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    // fields taken on latch_ad, sob_m kept
    function automatic cpu_status_t latch_rule(cpu_pins_t p, logic t02, cpu_status_t old);
        cpu_status_t s;
        s          = old;
        s.sob_x    = p.sob_mx | t02 | p.ef;     // 8-bit index on C02 or in emulation
        s.sync_vpa = p.sync_vpa;
        s.mln      = p.mln;
        s.vpn      = p.vpn;
        s.vda      = p.vda | t02;
        s.ef       = p.ef | t02;
        s.rwn      = p.rwn;
        return s;
    endfunction

    function automatic logic m_rule(logic sob_mx, logic t02, logic ef_r);
        return sob_mx | t02 | ef_r;
    endfunction

    function automatic logic [3:0] line_rule(irq_ctrl_t c, logic irq_n, logic nmi_n);
        return {c.force_resn,
                (irq_n & c.force_irqn) | c.block_irq,
                (nmi_n & c.force_nmin) | c.block_nmi,
                c.force_abortn | c.block_abort};
    endfunction

    function automatic logic [2:0] drive_rule(logic rwn, logic phi2, logic rdn, logic rdn_prev,
                                              logic be);
        return {rwn & phi2, rdn & rdn_prev, ~be};
    endfunction

    function automatic logic [6:0] pin_map(gpio_regs_t r, logic blink);
        logic [6:0] p;
        p[6] = r.ddra[3] ? ~r.ora[3] : 1'b1;    // nes clock, idle high
        p[5] = r.ddra[2] ? ~r.ora[2] : 1'b1;    // nes latch
        p[4] = r.ddra[1];                       // scl driven
        p[3] = r.ora[1];
        p[2] = r.ddra[0] & ~r.ora[0];           // sda pulled low
        p[1] = r.ddrb[1] ? r.orb[1] : 1'b1;
        p[0] = r.ddrb[0] ? r.orb[0] : blink;
        return p;
    endfunction

    function automatic logic [7:0] read_map(logic [GPIO_REG_AW-1:0] addr, gpio_regs_t r,
                                            logic [6:0] pins, logic [1:0] nes, logic sc,
                                            logic sd);
        case (addr)
            VIA_ORB:  return {6'b110000, pins[1:0]};
            VIA_ORA:  return {nes[0], nes[1], 2'b11, ~pins[6], ~pins[5], sc, sd};
            VIA_DDRB: return r.ddrb;
            VIA_DDRA: return r.ddra;
            default:  return 8'hFF;
        endcase
    endfunction

    always @(posedge clk6x)
    begin
        type02_m <= cputype02;      // strap seen one cycle late
        if (reset_i)
        begin
            ab_m        <= '0;
            st_m        <= '0;
            regs_m      <= '0;
            mrdn_m      <= 1'b1;
            blink_cnt_m <= 0;
            blink_m     <= 1'b0;
        end
        else
        begin
            if (strobes.latch_ad)
            begin
                ab_m <= {ca, mal};
                st_m <= latch_rule(cpu_pins, type02_m, st_m);
            end
            if (strobes.release_wr)
                st_m.sob_m <= m_rule(cpu_pins.sob_mx, type02_m, st_m.ef);
            if (slv.req && slv.datawr_valid && !slv.rwn)
            begin
                case (slv.addr)
                    VIA_ORB:  regs_m.orb  <= slv.datawr;
                    VIA_ORA:  regs_m.ora  <= slv.datawr;
                    VIA_DDRB: regs_m.ddrb <= slv.datawr;
                    VIA_DDRA: regs_m.ddra <= slv.datawr;
                    default:  ;
                endcase
            end
            mrdn_m <= mrdn;
            if (!regs_m.ddrb[0])    // blinker runs while led0 is free
            begin
                if (blink_cnt_m == BLINK_TOP - 1)
                begin
                    blink_cnt_m <= 0;
                    blink_m     <= ~blink_m;
                end
                else
                    blink_cnt_m <= blink_cnt_m + 1;
            end
        end
    end

    always_comb
    begin
        exp_lines = line_rule(irq_ctrl, virqn, nmi_req_n);
        exp_drive = drive_rule(cpu_pins.rwn, cphi2, mrdn, mrdn_m, cbe);
        exp_pins  = pin_map(regs_m, blink_m);
        exp_rd    = read_map(slv.addr, regs_m, exp_pins, nesdata, i2c_scl, i2c_sda);
        rd_valid  = slv.req & slv.rwn;
        exp_trace          = '0;
        exp_trace.mah_hi   = mah[MAH_W-1 -: 8];
        exp_trace.addr     = ab_m;
        exp_trace.cd       = cd;
        exp_trace.sob_x    = st_m.sob_x;
        exp_trace.cresn    = exp_lines[3];
        exp_trace.cirqn    = exp_lines[2];
        exp_trace.cnmin    = exp_lines[1];
        exp_trace.cabortn  = exp_lines[0];
        exp_trace.crdy     = crdy;
        exp_trace.sob_m    = st_m.sob_m;
        exp_trace.sync_vpa = st_m.sync_vpa;
        exp_trace.mln      = st_m.mln;
        exp_trace.vpn      = st_m.vpn;
        exp_trace.vda      = st_m.vda;
        exp_trace.ef       = st_m.ef;
        exp_trace.rwn      = st_m.rwn;
    end

    task automatic drive_random();
        slv_bus_t s;
        strobes.latch_ad   <= (take_bits(2) == 3);   // one in four cycles
        strobes.release_wr <= (take_bits(2) == 3);
        ca       <= CAH_W'(take_bits(CAH_W));
        mal      <= MAL_W'(take_bits(MAL_W));
        cpu_pins <= cpu_pins_t'(7'(take_bits(7)));
        if (take_bits(3) == 0)
            cputype02 <= ~cputype02;                // cpu type flips now and then
        cd        <= DB_W'(take_bits(DB_W));
        mah       <= MAH_W'(take_bits(MAH_W));
        crdy      <= 1'(take_bits(1));
        cphi2     <= 1'(take_bits(1));
        cbe       <= 1'(take_bits(1));
        mrdn      <= 1'(take_bits(1));
        irq_ctrl  <= irq_ctrl_t'(7'(take_bits(7)));
        virqn     <= 1'(take_bits(1));
        nmi_req_n <= 1'(take_bits(1));
        nesdata   <= 2'(take_bits(2));
        i2c_scl   <= 1'(take_bits(1));
        i2c_sda   <= 1'(take_bits(1));
        s.addr         = GPIO_REG_AW'(take_bits(2));    // the four port registers
        s.datawr       = DB_W'(take_bits(DB_W));
        s.datawr_valid = 1'(take_bits(1));
        s.req          = 1'(take_bits(1));
        s.rwn          = 1'(take_bits(1));
        slv <= s;
    endtask

    task automatic wait_blink_toggle();
        logic start;
        int   n;
        @(negedge clk6x);
        start = cpuled[0];
        n     = 0;
        while (cpuled[0] == start && n < BLINK_WAIT)
        begin
            @(negedge clk6x);
            n++;
        end
        if (cpuled[0] == start)
        begin
            other_errs++;
            $display("blinker: LED0 did not toggle within %0d cycles", BLINK_WAIT);
        end
    endtask

    initial
    begin
        lfsr_r     = 16'd22;
        other_errs = 0;
        reset_i    = 1'b1;
        strobes    = '0;
        ca         = '0;
        mal        = '0;
        cpu_pins   = '0;
        cputype02  = 1'b0;
        cd         = '0;
        mah        = '0;
        crdy       = 1'b1;
        cphi2      = 1'b0;
        cbe        = 1'b1;
        mrdn       = 1'b1;
        irq_ctrl   = '0;
        virqn      = 1'b1;
        nmi_req_n  = 1'b1;
        slv        = '0;
        nesdata    = '0;
        i2c_scl    = 1'b1;
        i2c_sda    = 1'b1;
        repeat (RESET_CYC) @(posedge clk6x);
        reset_i <= 1'b0;
        wait_blink_toggle();        // idle values checked by chk0 meanwhile
        repeat (RAND_CYC)
        begin
            @(posedge clk6x);
            drive_random();
        end
        @(posedge clk6x);
        slv     <= '0;
        strobes <= '0;
        repeat (2) @(posedge clk6x);
        prop_errs = dut0.smp0.props_smp.fail_cnt + dut0.via1.props_via.fail_cnt;
        $display("errors: %0d compare, %0d assertion, %0d other",
                 check_errs, prop_errs, other_errs);
        if (check_errs + prop_errs + other_errs == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // run limit
    initial cycle_cnt = 0;
    always @(posedge clk6x)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

/* list.f */
src/nora_pkg.sv
src/blinker.sv
src/cpu_bus_sampler.sv
src/cpu_pin_ctrl.sv
src/via_gpio.sv
src/nora_top.sv
bench/nora_props.sv
bench/nora_checker.sv
bench/nora_tb.sv

/* src/blinker.sv */
// led blink divider
`timescale 1ns/100ps

module blinker (
    input  logic clk6x,
    input  logic reset_i,
    input  logic blink_en_i,    // low while software owns the led
    output logic led_o
);
    import nora_pkg::*;

    logic [$clog2(BLINK_TOP)-1:0] cnt_r;    // toggle divider

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            cnt_r <= '0;
            led_o <= 1'b0;
        end
        else if (blink_en_i)
        begin
            if (cnt_r == BLINK_TOP - 1)
            begin
                cnt_r <= '0;            // wrap and flip
                led_o <= ~led_o;
            end
            else
                cnt_r <= cnt_r + 1'b1;
        end
        // disabled: counter and led hold
    end

endmodule

/* src/cpu_bus_sampler.sv */
// cpu bus status sampler and trace
`timescale 1ns/100ps

module cpu_bus_sampler (
    input  logic                          clk6x,
    input  logic                          reset_i,
    input  nora_pkg::phase_strobes_t      strobes_i,
    input  logic [nora_pkg::CAB_W-1:0]    cpu_ab_i,       // {CA, MAL}
    input  nora_pkg::cpu_pins_t           cpu_pins_i,
    input  logic                          cputype02_i,    // 1 = 65C02, 0 = 65C816
    input  logic [nora_pkg::DB_W-1:0]     cd_i,
    input  logic [nora_pkg::MAH_W-1:0]    mah_i,
    input  logic                          cresn_i,
    input  logic                          cirqn_i,
    input  logic                          cnmin_i,
    input  logic                          cabortn_i,
    input  logic                          crdy_i,
    output nora_pkg::trace_t              trace_o
);
    import nora_pkg::*;

    logic               cputype02_r;    // board strap, resampled each cycle
    logic [CAB_W-1:0]   cpu_ab_r;
    cpu_status_t        status_r;
    logic [TRACE_W-1:0] trace_bits;

    always_ff @(posedge clk6x)
        cputype02_r <= cputype02_i;

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
        begin
            cpu_ab_r <= '0;
            status_r <= '0;
        end
        else
        begin
            if (strobes_i.latch_ad)     // phi2 rising edge
            begin
                cpu_ab_r          <= cpu_ab_i;
                // X flag, 8-bit regs forced in emulation or on a C02
                status_r.sob_x    <= cpu_pins_i.sob_mx | cputype02_r | cpu_pins_i.ef;
                status_r.sync_vpa <= cpu_pins_i.sync_vpa;
                status_r.mln      <= cpu_pins_i.mln;
                status_r.vpn      <= cpu_pins_i.vpn;
                status_r.vda      <= cpu_pins_i.vda | cputype02_r;  // C02 has no VDA pin
                status_r.ef       <= cpu_pins_i.ef | cputype02_r;   // C02 is always emulation
                status_r.rwn      <= cpu_pins_i.rwn;
            end
            if (strobes_i.release_wr)   // M valid at phi2 fall
                status_r.sob_m <= cpu_pins_i.sob_mx | cputype02_r | status_r.ef;
        end
    end

    // byte 5 takes the top 8 of MAH, byte 2 the live data bus
    assign trace_bits = {
        mah_i[MAH_W-1 -: 8],
        cpu_ab_r,
        cd_i,
        3'b000,
        status_r.sob_x,
        cresn_i,
        cirqn_i,
        cnmin_i,
        cabortn_i,
        crdy_i,
        status_r.sob_m,
        status_r.sync_vpa,
        status_r.mln,
        status_r.vpn,
        status_r.vda,
        status_r.ef,
        status_r.rwn
    };

    assign trace_o = trace_t'(trace_bits);

endmodule

/* src/cpu_pin_ctrl.sv */
// cpu interrupt lines and bus drive enables
`timescale 1ns/100ps

module cpu_pin_ctrl (
    input  logic                  clk6x,
    input  logic                  reset_i,
    input  nora_pkg::irq_ctrl_t   irq_ctrl_i,
    input  logic                  virqn_i,        // vera/aura/enet irq, active low
    input  logic                  nmi_req_n_i,    // nmi request, active low
    input  logic                  crwn_i,
    input  logic                  cphi2_i,
    input  logic                  cbe_i,
    input  logic                  mrdn_i,
    output logic                  cresn_o,
    output logic                  cirqn_o,
    output logic                  cnmin_o,
    output logic                  cabortn_o,
    output logic                  cd_drive_o,     // fpga drives CD
    output logic                  md_drive_o,     // fpga drives MD
    output logic                  mal_drive_o     // fpga drives MAL
);
    import nora_pkg::*;

    irq_ctrl_t ctl;
    logic      mrdn_d_r;    // MRDn one cycle back

    assign ctl = irq_ctrl_i;

    // reset comes straight from the debugger
    assign cresn_o = ctl.force_resn;

    // request AND force, then block wins
    assign cirqn_o   = (virqn_i & ctl.force_irqn) | ctl.block_irq;
    assign cnmin_o   = (nmi_req_n_i & ctl.force_nmin) | ctl.block_nmi;
    assign cabortn_o = ctl.force_abortn | ctl.block_abort;     // no external abort source

    // CD only while the cpu reads, and only in phi2 high (816 puts bank on CD in phi1)
    assign cd_drive_o = crwn_i & cphi2_i;

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
            mrdn_d_r <= 1'b1;   // idle, no read
        else
            mrdn_d_r <= mrdn_i;
    end

    // sram releases MD after MRDn rises, so wait one cycle for turn-around
    assign md_drive_o = mrdn_i & mrdn_d_r;

    // MAL shared with the cpu, hands off while cpu bus enabled
    assign mal_drive_o = ~cbe_i;

endmodule

/* src/nora_pkg.sv */
// nora glue shared definitions
package nora_pkg;

    localparam int DB_W        = 8;     // cpu and memory data bus byte
    localparam int CAB_W       = 16;    // full cpu address
    localparam int CAH_W       = 4;     // cpu address high nibble, CA[15:12]
    localparam int MAL_W       = 12;    // shared low memory address
    localparam int MAH_W       = 9;     // private high memory address, MAH[20:12]
    localparam int TRACE_W     = 48;    // bus trace word
    localparam int GPIO_REG_AW = 4;     // via register address

    // short blink period, keeps simulation fast
    localparam int BLINK_TOP = 16;

    // 65C22 register offsets
    localparam logic [GPIO_REG_AW-1:0] VIA_ORB  = 4'd0;
    localparam logic [GPIO_REG_AW-1:0] VIA_ORA  = 4'd1;
    localparam logic [GPIO_REG_AW-1:0] VIA_DDRB = 4'd2;
    localparam logic [GPIO_REG_AW-1:0] VIA_DDRA = 4'd3;

    // raw cpu status pins
    typedef struct packed {
        logic sob_mx;       // SOB on C02, M/X on 816
        logic sync_vpa;     // SYNC on C02, VPA on 816
        logic mln;
        logic vpn;
        logic vda;          // 816 only
        logic ef;           // 816 only
        logic rwn;
    } cpu_pins_t;

    // status flags as sampled
    typedef struct packed {
        logic sob_x;
        logic sob_m;
        logic sync_vpa;
        logic mln;
        logic vpn;
        logic vda;
        logic ef;
        logic rwn;
    } cpu_status_t;

    // phaser strobes, only the first two are consumed here
    typedef struct packed {
        logic latch_ad;
        logic release_wr;
        logic setup_cs;
        logic release_cs;
    } phase_strobes_t;

    // debugger forcing and blocking of cpu control lines
    typedef struct packed {
        logic force_resn;
        logic force_irqn;       // 0 forces IRQ
        logic force_nmin;       // 0 forces NMI
        logic force_abortn;     // 0 forces ABORT
        logic block_irq;        // 1 blocks IRQ
        logic block_nmi;
        logic block_abort;
    } irq_ctrl_t;

    // internal slave bus, single cycle strobe
    typedef struct packed {
        logic [GPIO_REG_AW-1:0] addr;
        logic [DB_W-1:0]        datawr;
        logic                   datawr_valid;
        logic                   req;
        logic                   rwn;    // 1 = read
    } slv_bus_t;

    typedef struct packed {
        logic [DB_W-1:0] ora;
        logic [DB_W-1:0] orb;
        logic [DB_W-1:0] ddra;      // 1 = output
        logic [DB_W-1:0] ddrb;
    } gpio_regs_t;

    // trace word, byte 5 at the top
    typedef struct packed {
        logic [7:0]       mah_hi;       // MAH[20:13]
        logic [CAB_W-1:0] addr;         // bytes 4 and 3
        logic [DB_W-1:0]  cd;           // byte 2
        logic [2:0]       zero;         // byte 1 from here
        logic             sob_x;
        logic             cresn;
        logic             cirqn;
        logic             cnmin;
        logic             cabortn;
        logic             crdy;         // byte 0 from here
        logic             sob_m;
        logic             sync_vpa;
        logic             mln;
        logic             vpn;
        logic             vda;
        logic             ef;
        logic             rwn;
    } trace_t;

endpackage

/* src/nora_top.sv */
// nora system glue top
`timescale 1ns/100ps

module nora_top (
    input  logic                          clk6x,
    input  logic                          reset_i,
    // phaser strobes
    input  nora_pkg::phase_strobes_t      strobes_i,
    // cpu side
    input  logic [nora_pkg::CAH_W-1:0]    ca_i,           // CA[15:12]
    input  logic [nora_pkg::MAL_W-1:0]    mal_i,          // shared low address
    input  nora_pkg::cpu_pins_t           cpu_pins_i,
    input  logic                          cputype02_i,    // board strap
    input  logic [nora_pkg::DB_W-1:0]     cd_i,
    input  logic [nora_pkg::MAH_W-1:0]    mah_i,
    input  logic                          crdy_i,
    input  logic                          cphi2_i,
    input  logic                          cbe_i,
    input  logic                          mrdn_i,
    // interrupt sources
    input  nora_pkg::irq_ctrl_t           irq_ctrl_i,
    input  logic                          virqn_i,
    input  logic                          nmi_req_n_i,
    // slave bus
    input  nora_pkg::slv_bus_t            slv_i,
    output logic [nora_pkg::DB_W-1:0]     slv_datard_o,
    // board gpio
    input  logic [1:0]                    nesdata_i,
    input  logic                          i2c_scl_i,
    input  logic                          i2c_sda_i,
    output logic                          nesclock_o,
    output logic                          neslatch_o,
    output logic                          scl_drive_o,
    output logic                          scl_o,
    output logic                          sda_pull_o,
    output logic [1:0]                    cpuled_o,
    // cpu control and drive enables
    output logic                          cresn_o,
    output logic                          cirqn_o,
    output logic                          cnmin_o,
    output logic                          cabortn_o,
    output logic                          cd_drive_o,
    output logic                          md_drive_o,
    output logic                          mal_drive_o,
    output nora_pkg::trace_t              trace_o
);
    import nora_pkg::*;

    logic [CAB_W-1:0] cpu_ab;       // CA high nibble on top of MAL
    logic             blink_led;
    logic             blink_en;

    assign cpu_ab = {ca_i, mal_i};

    blinker blnk0 (
        .clk6x      (clk6x),
        .reset_i    (reset_i),
        .blink_en_i (blink_en),
        .led_o      (blink_led)
    );

    cpu_bus_sampler smp0 (
        .clk6x       (clk6x),
        .reset_i     (reset_i),
        .strobes_i   (strobes_i),
        .cpu_ab_i    (cpu_ab),
        .cpu_pins_i  (cpu_pins_i),
        .cputype02_i (cputype02_i),
        .cd_i        (cd_i),
        .mah_i       (mah_i),
        .cresn_i     (cresn_o),     // trace sees the lines as driven
        .cirqn_i     (cirqn_o),
        .cnmin_i     (cnmin_o),
        .cabortn_i   (cabortn_o),
        .crdy_i      (crdy_i),
        .trace_o     (trace_o)
    );

    cpu_pin_ctrl pin0 (
        .clk6x       (clk6x),
        .reset_i     (reset_i),
        .irq_ctrl_i  (irq_ctrl_i),
        .virqn_i     (virqn_i),
        .nmi_req_n_i (nmi_req_n_i),
        .crwn_i      (cpu_pins_i.rwn),
        .cphi2_i     (cphi2_i),
        .cbe_i       (cbe_i),
        .mrdn_i      (mrdn_i),
        .cresn_o     (cresn_o),
        .cirqn_o     (cirqn_o),
        .cnmin_o     (cnmin_o),
        .cabortn_o   (cabortn_o),
        .cd_drive_o  (cd_drive_o),
        .md_drive_o  (md_drive_o),
        .mal_drive_o (mal_drive_o)
    );

    via_gpio via1 (
        .clk6x        (clk6x),
        .reset_i      (reset_i),
        .slv_i        (slv_i),
        .slv_datard_o (slv_datard_o),
        .blink_i      (blink_led),
        .nesdata_i    (nesdata_i),
        .i2c_scl_i    (i2c_scl_i),
        .i2c_sda_i    (i2c_sda_i),
        .nesclock_o   (nesclock_o),
        .neslatch_o   (neslatch_o),
        .scl_drive_o  (scl_drive_o),
        .scl_o        (scl_o),
        .sda_pull_o   (sda_pull_o),
        .cpuled_o     (cpuled_o),
        .blink_en_o   (blink_en)
    );

endmodule

/* src/via_gpio.sv */
// via gpio block with board pin map
`timescale 1ns/100ps

module via_gpio (
    input  logic                       clk6x,
    input  logic                       reset_i,
    input  nora_pkg::slv_bus_t         slv_i,
    output logic [nora_pkg::DB_W-1:0]  slv_datard_o,
    input  logic                       blink_i,        // blinker led fallback
    input  logic [1:0]                 nesdata_i,      // game pad serial data 0 and 1
    input  logic                       i2c_scl_i,
    input  logic                       i2c_sda_i,
    output logic                       nesclock_o,
    output logic                       neslatch_o,
    output logic                       scl_drive_o,
    output logic                       scl_o,
    output logic                       sda_pull_o,     // 1 pulls SDA low
    output logic [1:0]                 cpuled_o,
    output logic                       blink_en_o
);
    import nora_pkg::*;

    gpio_regs_t      regs_r;
    logic [DB_W-1:0] ira;       // port A pin levels
    logic [DB_W-1:0] irb;       // port B pin levels
    logic            wr_en;

    assign wr_en = slv_i.req & slv_i.datawr_valid & ~slv_i.rwn;

    always_ff @(posedge clk6x)
    begin
        if (reset_i)
            regs_r <= '0;       // all pins input after reset
        else if (wr_en)
        begin
            case (slv_i.addr)
                VIA_ORB:  regs_r.orb  <= slv_i.datawr;
                VIA_ORA:  regs_r.ora  <= slv_i.datawr;
                VIA_DDRB: regs_r.ddrb <= slv_i.datawr;
                VIA_DDRA: regs_r.ddra <= slv_i.datawr;
                default:  ;             // timers etc not present
            endcase
        end
    end

    // port A pins: pad data, clock/latch seen inverted, i2c
    assign ira = {
        nesdata_i[0],
        nesdata_i[1],
        1'b1,
        1'b1,
        ~nesclock_o,
        ~neslatch_o,
        i2c_scl_i,
        i2c_sda_i
    };

    // port B reads back the leds
    assign irb = {6'b110000, cpuled_o[1], cpuled_o[0]};

    // read mux, combinational
    always_comb
    begin
        slv_datard_o = 8'hFF;   // idle bus
        if (slv_i.req && slv_i.rwn)
        begin
            case (slv_i.addr)
                VIA_ORB:  slv_datard_o = irb;
                VIA_ORA:  slv_datard_o = ira;
                VIA_DDRB: slv_datard_o = regs_r.ddrb;
                VIA_DDRA: slv_datard_o = regs_r.ddra;
                default:  slv_datard_o = 8'hFF;
            endcase
        end
    end

    // pad clock and latch inverted by the level shifter, idle high
    assign nesclock_o = regs_r.ddra[3] ? ~regs_r.ora[3] : 1'b1;
    assign neslatch_o = regs_r.ddra[2] ? ~regs_r.ora[2] : 1'b1;

    // SCL push-pull when output, else released
    assign scl_drive_o = regs_r.ddra[1];
    assign scl_o       = regs_r.ora[1];

    // SDA open drain
    assign sda_pull_o = regs_r.ddra[0] & ~regs_r.ora[0];

    // led0 falls back to the blinker, led1 idles high
    assign cpuled_o[0] = regs_r.ddrb[0] ? regs_r.orb[0] : blink_i;
    assign cpuled_o[1] = regs_r.ddrb[1] ? regs_r.orb[1] : 1'b1;

    assign blink_en_o = ~regs_r.ddrb[0];   // blink only while led0 is not software owned

endmodule
